// ==== Makefile ====
# Verilator flow for the pipeline testbench
TOP := tb_top

.PHONY: all lint sim clean

all: sim

lint:
	verilator --lint-only --timing --assert --timescale 1ns/100ps \
		-f project.f --top-module $(TOP)

sim:
	verilator --binary --timing --assert --timescale 1ns/100ps \
		-f project.f --top-module $(TOP) -o sim_$(TOP)
	./obj_dir/sim_$(TOP) > sim.log 2>&1 || true
	cat sim.log
	@if grep -q "Result: FAILED" sim.log; then exit 1; fi
	@grep -q "Result: PASSED" sim.log

clean:
	rm -rf obj_dir sim.log

// ==== design/exec_pipe.sv ====
`timescale 1ns/100ps
`include "pipe_settings.svh"

module exec_pipe (
    input  logic                    clk,
    input  logic                    reset,
    input  logic                    fifo_valid,
    input  pipe_pkg::fetch_entry_t  fifo_entry,
    input  logic                    flush_to_id_reg,
    input  logic                    flush_to_reg_ex1,
    input  logic                    flush_to_ex1_ex2,
    input  logic                    flush_to_ex2_wb,
    output logic                    flush_from_id,
    output logic                    flush_from_reg,
    output logic                    flush_from_ex1,
    output logic                    flush_by_priv,
    output logic                    flush_from_ex2,
    output logic                    flush_from_wb,
    output logic [`PIPE_ADDR_W-1:0] id_target,
    output logic [`PIPE_ADDR_W-1:0] reg_target,
    output logic [`PIPE_ADDR_W-1:0] ex1_target,
    output logic [`PIPE_ADDR_W-1:0] ex2_target,
    output logic [`PIPE_ADDR_W-1:0] wb_target,
    output logic                    retire_valid,
    output logic [`PIPE_ADDR_W-1:0] retire_pc,
    output logic [31:0]             retire_insn
);

    localparam int N_STAGES = 5;
    localparam int ST_ID    = 0;
    localparam int ST_REG   = 1;
    localparam int ST_EX1   = 2;
    localparam int ST_EX2   = 3;
    localparam int ST_WB    = 4;

    logic [N_STAGES-1:0]   stage_in_valid;
    logic [N_STAGES-1:0]   stage_flush;
    logic [N_STAGES-1:0]   stage_valid;
    pipe_pkg::pipe_entry_t stage_in    [N_STAGES];
    pipe_pkg::pipe_entry_t stage_entry [N_STAGES];

    // id loads the FIFO head, which is already gated by older flushes
    assign stage_in_valid = {stage_valid[N_STAGES-2:0], fifo_valid};
    assign stage_flush    = {flush_to_ex2_wb, flush_to_ex1_ex2, flush_to_reg_ex1,
                             flush_to_id_reg, 1'b0};

    always_comb begin
        // decode on the way into id
        stage_in[ST_ID] = '{pc:   fifo_entry.pc,
                            insn: fifo_entry.insn,
                            code: pipe_pkg::insn_code(fifo_entry.insn)};
        for (int i = 1; i < N_STAGES; i++) begin
            stage_in[i] = stage_entry[i-1];
        end
    end

    for (genvar i = 0; i < N_STAGES; i++) begin : g_stage
        stage_reg #(.payload_t(pipe_pkg::pipe_entry_t)) u_stage (
            .clk        (clk),
            .reset      (reset),
            .in_valid   (stage_in_valid[i]),
            .in_payload (stage_in[i]),
            .flush      (stage_flush[i]),
            .out_valid  (stage_valid[i]),
            .out_payload(stage_entry[i])
        );
    end

    // a stage redirects when its valid entry names that stage
    assign flush_from_id  = stage_valid[ST_ID]  && stage_entry[ST_ID].code  == pipe_pkg::rc_at_id;
    assign flush_from_reg = stage_valid[ST_REG] && stage_entry[ST_REG].code == pipe_pkg::rc_at_reg;
    assign flush_from_ex1 = stage_valid[ST_EX1] && stage_entry[ST_EX1].code == pipe_pkg::rc_at_ex1;
    assign flush_by_priv  = stage_valid[ST_EX1] && stage_entry[ST_EX1].code == pipe_pkg::rc_priv;
    assign flush_from_ex2 = stage_valid[ST_EX2] && stage_entry[ST_EX2].code == pipe_pkg::rc_at_ex2;
    assign flush_from_wb  = stage_valid[ST_WB]  && stage_entry[ST_WB].code  == pipe_pkg::rc_at_wb;

    assign id_target  = pipe_pkg::insn_target(stage_entry[ST_ID].insn);
    assign reg_target = pipe_pkg::insn_target(stage_entry[ST_REG].insn);
    assign ex1_target = pipe_pkg::insn_target(stage_entry[ST_EX1].insn);
    assign ex2_target = pipe_pkg::insn_target(stage_entry[ST_EX2].insn);
    assign wb_target  = pipe_pkg::insn_target(stage_entry[ST_WB].insn);

    // whatever is valid in wb retires, redirecting or not
    assign retire_valid = stage_valid[ST_WB];
    assign retire_pc    = stage_entry[ST_WB].pc;
    assign retire_insn  = stage_entry[ST_WB].insn;

endmodule

// ==== design/fetch_unit.sv ====
`timescale 1ns/100ps
`include "pipe_settings.svh"

module fetch_unit (
    input  logic                    clk,
    input  logic                    reset,
    output logic                    wb_cyc,
    output logic                    wb_stb,
    output logic                    wb_we,
    output logic [`PIPE_ADDR_W-1:0] wb_adr,
    input  logic [31:0]             wb_dat_i,
    input  logic                    wb_ack,
    input  logic                    redirect_valid,
    input  logic [`PIPE_ADDR_W-1:0] redirect_pc,
    input  logic                    flush_to_fetch,
    input  logic                    flush_to_fifo_id,
    output logic                    flush_from_if1,
    output logic [`PIPE_ADDR_W-1:0] if1_target,
    output logic                    fifo_valid,
    output pipe_pkg::fetch_entry_t  fifo_entry
);

    localparam int PTR_W = $clog2(`PIPE_FIFO_DEPTH);
    localparam int CNT_W = $clog2(`PIPE_FIFO_DEPTH + 1);

    logic [`PIPE_ADDR_W-1:0] pc_q;
    logic [`PIPE_ADDR_W-1:0] adr_q;
    logic                    busy_q;
    logic                    drop_q;
    logic                    ack;
    logic                    room;
    logic                    start;
    pipe_pkg::fetch_entry_t  rsp_entry;
    logic                    if1_valid;
    pipe_pkg::fetch_entry_t  if1_entry;

    pipe_pkg::fetch_entry_t  fifo_mem [`PIPE_FIFO_DEPTH];
    logic [PTR_W-1:0]        rd_ptr;
    logic [PTR_W-1:0]        wr_ptr;
    logic [CNT_W-1:0]        count;
    logic                    push;
    logic                    pop;

    // classic read cycle, cyc and stb held together until ack
    assign wb_cyc = busy_q;
    assign wb_stb = busy_q;
    assign wb_we  = 1'b0;
    assign wb_adr = adr_q;
    assign ack    = busy_q & wb_ack;

    // room counts the word sitting in if1, busy is low here
    assign room  = (int'(count) + int'(if1_valid)) < `PIPE_FIFO_DEPTH;
    assign start = ~busy_q & ~flush_to_fetch & room;

    always_ff @(posedge clk) begin
        if (reset) begin
            busy_q <= 1'b0;
            drop_q <= 1'b0;
            pc_q   <= `PIPE_RESET_PC;
        end else begin
            if (start) begin
                busy_q <= 1'b1;
            end else if (ack) begin
                busy_q <= 1'b0;
            end
            // a flush mid-cycle lets the read finish, then discards it
            if (ack) begin
                drop_q <= 1'b0;
            end else if (busy_q && flush_to_fetch) begin
                drop_q <= 1'b1;
            end
            if (redirect_valid) begin
                pc_q <= redirect_pc;
            end else if (start) begin
                pc_q <= pc_q + `PIPE_ADDR_W'(4);
            end
        end
    end

    always_ff @(posedge clk) begin
        if (start) begin
            adr_q <= pc_q;
        end
    end

    assign rsp_entry = '{pc: adr_q, insn: wb_dat_i};

    // if1 response register
    stage_reg #(.payload_t(pipe_pkg::fetch_entry_t)) u_if1 (
        .clk        (clk),
        .reset      (reset),
        .in_valid   (ack & ~drop_q),
        .in_payload (rsp_entry),
        .flush      (flush_to_fetch),
        .out_valid  (if1_valid),
        .out_payload(if1_entry)
    );

    // early redirect, the word itself still goes into the FIFO
    assign flush_from_if1 = if1_valid &&
                            pipe_pkg::insn_code(if1_entry.insn) == pipe_pkg::rc_at_if1;
    assign if1_target     = pipe_pkg::insn_target(if1_entry.insn);

    assign push       = if1_valid & ~flush_to_fifo_id;
    assign fifo_valid = (count != '0) & ~flush_to_fifo_id;
    assign pop        = fifo_valid;
    assign fifo_entry = fifo_mem[rd_ptr];

    always_ff @(posedge clk) begin
        if (reset || flush_to_fifo_id) begin
            rd_ptr <= '0;
            wr_ptr <= '0;
            count  <= '0;
        end else begin
            if (push) begin
                wr_ptr <= (wr_ptr == PTR_W'(`PIPE_FIFO_DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
            end
            if (pop) begin
                rd_ptr <= (rd_ptr == PTR_W'(`PIPE_FIFO_DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
            end
            count <= count + CNT_W'(push) - CNT_W'(pop);
        end
    end

    always_ff @(posedge clk) begin
        if (push) begin
            fifo_mem[wr_ptr] <= if1_entry;
        end
    end

endmodule

// ==== design/flush_unit.sv ====
`timescale 1ns/100ps
`include "pipe_settings.svh"

module flush_unit (
    input  logic                    flush_from_if1,
    input  logic                    flush_from_id,
    input  logic                    flush_from_reg,
    input  logic                    flush_from_ex1,
    input  logic                    flush_by_priv,
    input  logic                    flush_from_ex2,
    input  logic                    flush_from_wb,
    input  logic [`PIPE_ADDR_W-1:0] if1_target,
    input  logic [`PIPE_ADDR_W-1:0] id_target,
    input  logic [`PIPE_ADDR_W-1:0] reg_target,
    input  logic [`PIPE_ADDR_W-1:0] ex1_target,
    input  logic [`PIPE_ADDR_W-1:0] ex2_target,
    input  logic [`PIPE_ADDR_W-1:0] wb_target,
    output logic                    flush_to_fetch,
    output logic                    flush_to_fifo_id,
    output logic                    flush_to_id_reg,
    output logic                    flush_to_reg_ex1,
    output logic                    flush_to_ex1_ex2,
    output logic                    flush_to_ex2_wb,
    output logic                    redirect_valid,
    output logic [`PIPE_ADDR_W-1:0] redirect_pc
);

    // each register is cleared by any source older than it
    assign flush_to_ex2_wb  = flush_from_wb;
    assign flush_to_ex1_ex2 = flush_to_ex2_wb | flush_from_ex2;
    assign flush_to_reg_ex1 = flush_to_ex1_ex2 | flush_by_priv | flush_from_ex1;
    assign flush_to_id_reg  = flush_to_reg_ex1 | flush_from_reg;
    assign flush_to_fifo_id = flush_to_id_reg | flush_from_id;

    // if1 only kills the read behind it
    assign flush_to_fetch   = flush_to_fifo_id | flush_from_if1;
    assign redirect_valid   = flush_to_fetch;

    // oldest source wins, priv sits between ex2 and ex1
    always_comb begin
        if (flush_from_wb) begin
            redirect_pc = wb_target;
        end else if (flush_from_ex2) begin
            redirect_pc = ex2_target;
        end else if (flush_by_priv) begin
            redirect_pc = `PIPE_TRAP_VECTOR;
        end else if (flush_from_ex1) begin
            redirect_pc = ex1_target;
        end else if (flush_from_reg) begin
            redirect_pc = reg_target;
        end else if (flush_from_id) begin
            redirect_pc = id_target;
        end else begin
            redirect_pc = if1_target;
        end
    end

endmodule

// ==== design/pipe_pkg.sv ====
`include "pipe_settings.svh"

package pipe_pkg;

    // instruction bits 31:29, the stage that redirects the PC
    typedef enum logic [2:0] {
        rc_none   = 3'd0,
        rc_at_if1 = 3'd1,
        rc_at_id  = 3'd2,
        rc_at_reg = 3'd3,
        rc_at_ex1 = 3'd4,
        rc_priv   = 3'd5,  // resolved in ex1, target is the trap vector
        rc_at_ex2 = 3'd6,
        rc_at_wb  = 3'd7
    } redirect_code_e;

    // word as it comes back from the fetch port
    typedef struct packed {
        logic [`PIPE_ADDR_W-1:0] pc;
        logic [31:0]             insn;
    } fetch_entry_t;

    // what travels through id..wb
    typedef struct packed {
        logic [`PIPE_ADDR_W-1:0] pc;
        logic [31:0]             insn;
        redirect_code_e          code;
    } pipe_entry_t;

    function automatic redirect_code_e insn_code(input logic [31:0] insn);
        return redirect_code_e'(insn[31:29]);
    endfunction

    // target sits in the low half, forced to a word boundary
    function automatic logic [`PIPE_ADDR_W-1:0] insn_target(input logic [31:0] insn);
        return {insn[`PIPE_ADDR_W-1:2], 2'b00};
    endfunction

endpackage

// ==== design/pipe_top.sv ====
`timescale 1ns/100ps
`include "pipe_settings.svh"

module pipe_top (
    input  logic                    clk,
    input  logic                    reset,
    output logic                    wb_cyc,
    output logic                    wb_stb,
    output logic                    wb_we,
    output logic [`PIPE_ADDR_W-1:0] wb_adr,
    input  logic [31:0]             wb_dat_i,
    input  logic                    wb_ack,
    output logic                    retire_valid,
    output logic [`PIPE_ADDR_W-1:0] retire_pc,
    output logic [31:0]             retire_insn
);

    logic                    fifo_valid;
    pipe_pkg::fetch_entry_t  fifo_entry;

    // redirect sources and their targets
    logic                    flush_from_if1;
    logic                    flush_from_id;
    logic                    flush_from_reg;
    logic                    flush_from_ex1;
    logic                    flush_by_priv;
    logic                    flush_from_ex2;
    logic                    flush_from_wb;
    logic [`PIPE_ADDR_W-1:0] if1_target;
    logic [`PIPE_ADDR_W-1:0] id_target;
    logic [`PIPE_ADDR_W-1:0] reg_target;
    logic [`PIPE_ADDR_W-1:0] ex1_target;
    logic [`PIPE_ADDR_W-1:0] ex2_target;
    logic [`PIPE_ADDR_W-1:0] wb_target;

    // fan-out back to the stages
    logic                    flush_to_fetch;
    logic                    flush_to_fifo_id;
    logic                    flush_to_id_reg;
    logic                    flush_to_reg_ex1;
    logic                    flush_to_ex1_ex2;
    logic                    flush_to_ex2_wb;
    logic                    redirect_valid;
    logic [`PIPE_ADDR_W-1:0] redirect_pc;

    fetch_unit u_fetch (
        .clk             (clk),
        .reset           (reset),
        .wb_cyc          (wb_cyc),
        .wb_stb          (wb_stb),
        .wb_we           (wb_we),
        .wb_adr          (wb_adr),
        .wb_dat_i        (wb_dat_i),
        .wb_ack          (wb_ack),
        .redirect_valid  (redirect_valid),
        .redirect_pc     (redirect_pc),
        .flush_to_fetch  (flush_to_fetch),
        .flush_to_fifo_id(flush_to_fifo_id),
        .flush_from_if1  (flush_from_if1),
        .if1_target      (if1_target),
        .fifo_valid      (fifo_valid),
        .fifo_entry      (fifo_entry)
    );

    exec_pipe u_exec (
        .clk             (clk),
        .reset           (reset),
        .fifo_valid      (fifo_valid),
        .fifo_entry      (fifo_entry),
        .flush_to_id_reg (flush_to_id_reg),
        .flush_to_reg_ex1(flush_to_reg_ex1),
        .flush_to_ex1_ex2(flush_to_ex1_ex2),
        .flush_to_ex2_wb (flush_to_ex2_wb),
        .flush_from_id   (flush_from_id),
        .flush_from_reg  (flush_from_reg),
        .flush_from_ex1  (flush_from_ex1),
        .flush_by_priv   (flush_by_priv),
        .flush_from_ex2  (flush_from_ex2),
        .flush_from_wb   (flush_from_wb),
        .id_target       (id_target),
        .reg_target      (reg_target),
        .ex1_target      (ex1_target),
        .ex2_target      (ex2_target),
        .wb_target       (wb_target),
        .retire_valid    (retire_valid),
        .retire_pc       (retire_pc),
        .retire_insn     (retire_insn)
    );

    flush_unit u_flush (
        .flush_from_if1  (flush_from_if1),
        .flush_from_id   (flush_from_id),
        .flush_from_reg  (flush_from_reg),
        .flush_from_ex1  (flush_from_ex1),
        .flush_by_priv   (flush_by_priv),
        .flush_from_ex2  (flush_from_ex2),
        .flush_from_wb   (flush_from_wb),
        .if1_target      (if1_target),
        .id_target       (id_target),
        .reg_target      (reg_target),
        .ex1_target      (ex1_target),
        .ex2_target      (ex2_target),
        .wb_target       (wb_target),
        .flush_to_fetch  (flush_to_fetch),
        .flush_to_fifo_id(flush_to_fifo_id),
        .flush_to_id_reg (flush_to_id_reg),
        .flush_to_reg_ex1(flush_to_reg_ex1),
        .flush_to_ex1_ex2(flush_to_ex1_ex2),
        .flush_to_ex2_wb (flush_to_ex2_wb),
        .redirect_valid  (redirect_valid),
        .redirect_pc     (redirect_pc)
    );

endmodule

// ==== design/stage_reg.sv ====
`timescale 1ns/100ps

// one pipeline register, payload type chosen per instance
module stage_reg #(
    parameter type payload_t = logic
) (
    input  logic     clk,
    input  logic     reset,
    input  logic     in_valid,
    input  payload_t in_payload,
    input  logic     flush,
    output logic     out_valid,
    output payload_t out_payload
);

    // flush kills whatever would enter this register on this edge
    always_ff @(posedge clk) begin
        if (reset || flush) begin
            out_valid <= 1'b0;
        end else begin
            out_valid <= in_valid;
        end
    end

    // payload is only meaningful while out_valid is set
    always_ff @(posedge clk) begin
        if (in_valid) begin
            out_payload <= in_payload;
        end
    end

endmodule

// ==== dv/pipe_assertions.sv ====
`timescale 1ns/100ps
`include "pipe_settings.svh"

module pipe_assertions (
    input logic                    clk,
    input logic                    reset,
    input logic                    wb_cyc,
    input logic                    wb_stb,
    input logic [`PIPE_ADDR_W-1:0] wb_adr,
    input logic                    wb_ack,
    input logic                    retire_valid
);

    // number of failed assertions so far
    int fail_count = 0;

    // stb alone is never a bus request
    stb_needs_cyc: assert property (@(posedge clk) disable iff (reset) wb_stb |-> wb_cyc)
        else begin
            fail_count++;
            $error("wb_stb high without wb_cyc");
        end

    // address held until the slave answers
    adr_stable_in_wait: assert property (@(posedge clk) disable iff (reset)
        (wb_cyc && wb_stb && !wb_ack) |=> (wb_cyc && $stable(wb_adr)))
        else begin
            fail_count++;
            $error("wb_adr changed while the read waited for wb_ack");
        end

    no_retire_in_reset: assert property (@(posedge clk) (reset && $past(reset)) |-> !retire_valid)
        else begin
            fail_count++;
            $error("retire_valid high during reset");
        end

    // first cycle out of reset, nothing can have reached wb yet
    no_retire_after_reset: assert property (@(posedge clk) $fell(reset) |-> !retire_valid)
        else begin
            fail_count++;
            $error("retire_valid high in the cycle after reset");
        end

endmodule

// ==== dv/pipe_vectors.hex ====
// @word-index then instruction words, every word not listed reads as a nop
// from @100 the expected retire PCs in order, closed by ffffffff
@003 40000040
@012 60000080
@021 800000c0
@032 a0000000
@041 c0000140
@050 e0000180
@061 200001c0
@072 e0000200 40000300
@100 0000 0004 0008 000c 0040 0044 0048 0080
0084 00c0 00c4 00c8 0100 0104 0140 0180
0184 01c0 01c4 01c8 0200 0204 0208 020c
ffffffff

// ==== dv/tb_top.sv ====
`timescale 1ns/100ps
`include "pipe_settings.svh"

module tb_top;

    localparam int          CLK_PERIOD     = 40;
    localparam int          RESET_CYCLES   = 10;
    localparam int          PROG_WORDS     = 256;
    localparam int          EXP_BASE       = 256;
    localparam int          VEC_WORDS      = 320;
    localparam int          RETIRE_TIMEOUT = 200;
    localparam logic [31:0] LFSR_SEED      = 32'h64c9;
    localparam logic [31:0] LFSR_TAPS      = 32'ha300_0000;
    localparam logic [31:0] LIST_END       = 32'hffff_ffff;

    logic                    clk;
    logic                    reset;
    logic                    wb_cyc;
    logic                    wb_stb;
    logic                    wb_we;
    logic [`PIPE_ADDR_W-1:0] wb_adr;
    logic [31:0]             wb_dat_i = 32'h0;
    logic                    wb_ack = 1'b0;
    logic                    retire_valid;
    logic [`PIPE_ADDR_W-1:0] retire_pc;
    logic [31:0]             retire_insn;

    logic [31:0]             vectors  [VEC_WORDS];
    logic [31:0]             prog_mem [PROG_WORDS];
    logic [`PIPE_ADDR_W-1:0] exp_pc   [$];
    logic [31:0]             lfsr;
    logic [31:0]             lfsr_mid;
    logic                    mem_busy;
    logic [1:0]              wait_left;

    pipe_top dut (
        .clk         (clk),
        .reset       (reset),
        .wb_cyc      (wb_cyc),
        .wb_stb      (wb_stb),
        .wb_we       (wb_we),
        .wb_adr      (wb_adr),
        .wb_dat_i    (wb_dat_i),
        .wb_ack      (wb_ack),
        .retire_valid(retire_valid),
        .retire_pc   (retire_pc),
        .retire_insn (retire_insn)
    );

    bind pipe_top pipe_assertions u_assertions (
        .clk         (clk),
        .reset       (reset),
        .wb_cyc      (wb_cyc),
        .wb_stb      (wb_stb),
        .wb_adr      (wb_adr),
        .wb_ack      (wb_ack),
        .retire_valid(retire_valid)
    );

    function automatic logic [31:0] lfsr_next(input logic [31:0] state);
        if (state[0]) begin
            return (state >> 1) ^ LFSR_TAPS;
        end else begin
            return state >> 1;
        end
    endfunction

    // words outside the image read as nops tagged with their address
    function automatic logic [31:0] read_word(input logic [`PIPE_ADDR_W-1:0] adr);
        int idx;
        idx = int'(adr) / 4;
        if (idx < PROG_WORDS) begin
            return prog_mem[idx];
        end else begin
            return {16'h1e5a, adr};
        end
    endfunction

    // where the instruction after this one must come from
    function automatic logic [`PIPE_ADDR_W-1:0] next_pc(input logic [`PIPE_ADDR_W-1:0] pc,
                                                        input logic [31:0] insn);
        if (insn[31:29] == 3'd0) begin
            return pc + 16'd4;
        end else if (insn[31:29] == 3'd5) begin
            return `PIPE_TRAP_VECTOR;
        end else begin
            return {insn[15:2], 2'b00};
        end
    endfunction

    task automatic compare_value(input string name, input logic [31:0] got,
                                 input logic [31:0] expected);
        if (got !== expected) begin
            $display("MISMATCH %s: got 0x%h expected 0x%h", name, got, expected);
            $display("Result: FAILED");
            $fatal(1, "stopped at the first mismatch");
        end
    endtask

    task automatic load_vectors();
        int i;
        for (i = 0; i < VEC_WORDS; i++) begin
            if (i < PROG_WORDS) begin
                vectors[i] = {16'h1e5a, 16'(i * 4)};
            end else begin
                vectors[i] = LIST_END;
            end
        end
        $readmemh("dv/pipe_vectors.hex", vectors);
        for (i = 0; i < PROG_WORDS; i++) begin
            prog_mem[i] = vectors[i];
        end
        i = EXP_BASE;
        while (i < VEC_WORDS && vectors[i] != LIST_END) begin
            exp_pc.push_back(vectors[i][`PIPE_ADDR_W-1:0]);
            i++;
        end
    endtask

    // outputs are read on the falling edge, away from the register updates
    task automatic wait_retire(input int entry);
        int cycles;
        cycles = 0;
        @(negedge clk);
        while (retire_valid !== 1'b1) begin
            if (cycles >= RETIRE_TIMEOUT) begin
                $display("timeout: retirement %0d did not arrive within %0d cycles",
                         entry, RETIRE_TIMEOUT);
                $display("Result: FAILED");
                $fatal(1, "no retirement");
            end
            cycles++;
            @(negedge clk);
        end
    endtask

    task automatic check_retire_trace();
        logic [`PIPE_ADDR_W-1:0] prev_pc;
        logic [31:0]             prev_insn;
        int                      n;
        prev_pc   = '0;
        prev_insn = '0;
        for (n = 0; n < exp_pc.size(); n++) begin
            wait_retire(n);
            compare_value("retire_pc", 32'(retire_pc), 32'(exp_pc[n]));
            compare_value("retire_insn", retire_insn, read_word(exp_pc[n]));
            if (n > 0) begin
                compare_value("retire_pc after previous retire", 32'(retire_pc),
                              32'(next_pc(prev_pc, prev_insn)));
            end
            prev_pc   = exp_pc[n];
            prev_insn = read_word(exp_pc[n]);
        end
    endtask

    initial begin
        clk = 1'b0;
        forever begin
            #(CLK_PERIOD / 2) clk = ~clk;
        end
    end

    assign lfsr_mid = lfsr_next(lfsr);

    // classic slave, 0 to 3 wait states per read, ack lasts one cycle
    always @(posedge clk) begin
        if (reset) begin
            wb_ack    <= 1'b0;
            mem_busy  <= 1'b0;
            wait_left <= 2'd0;
            lfsr      <= LFSR_SEED;
        end else if (wb_ack) begin
            wb_ack   <= 1'b0;
            mem_busy <= 1'b0;
        end else if (wb_cyc && wb_stb) begin
            if (!mem_busy) begin
                // fetch port only reads
                compare_value("wb_we", 32'(wb_we), 32'h0);
                mem_busy  <= 1'b1;
                wait_left <= {lfsr_mid[0], lfsr[0]};
                lfsr      <= lfsr_next(lfsr_mid);
            end else if (wait_left != 2'd0) begin
                wait_left <= wait_left - 2'd1;
            end else begin
                wb_ack   <= 1'b1;
                wb_dat_i <= read_word(wb_adr);
            end
        end
    end

    initial begin
        reset <= 1'b1;
        load_vectors();
        repeat (RESET_CYCLES) @(posedge clk);
        reset <= 1'b0;
        check_retire_trace();
        if (exp_pc.size() > 0 && dut.u_assertions.fail_count == 0) begin
            $display("Result: PASSED");
            $finish;
        end else begin
            $display("empty expected list or failed assertions");
            $display("Result: FAILED");
            $fatal(1, "retire trace not confirmed");
        end
    end

endmodule

// ==== include/pipe_settings.svh ====
`ifndef PIPE_SETTINGS_SVH
`define PIPE_SETTINGS_SVH

// byte address width of the fetch port and of every PC
`define PIPE_ADDR_W 16

// fetch FIFO entries between if1 and id
`define PIPE_FIFO_DEPTH 4

// where a privileged flush sends the PC
`define PIPE_TRAP_VECTOR 16'h0100

// first fetch address after reset
`define PIPE_RESET_PC 16'h0000

`endif

// ==== project.f ====
+incdir+include
design/pipe_pkg.sv
design/stage_reg.sv
design/fetch_unit.sv
design/flush_unit.sv
design/exec_pipe.sv
design/pipe_top.sv
dv/pipe_assertions.sv
dv/tb_top.sv
